//--- source/CpuMacros_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// word width of the datapath and the memory port
`define DATA_WIDTH 32

// register index width for 32 registers
`define REG_ADDR_WIDTH 5

// instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define IMM_WIDTH 16

// control FSM state encoding width
`define STATE_WIDTH 4

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- source/CpuPkg.sv
`include "CpuMacros_macros.svh"

package CpuPkg;

    // primary opcodes of the supported subset
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        RType = 6'h00,
        J     = 6'h02,
        Beq   = 6'h04,
        Bne   = 6'h05,
        Lw    = 6'h23,
        Sw    = 6'h2B
    } Opcode;

    // R-type function codes
    typedef enum logic [`FUNCT_WIDTH-1:0] {
        Add = 6'h20,
        Sub = 6'h22,
        And = 6'h24,
        Or  = 6'h25,
        Slt = 6'h2A
    } Funct;

    // Reset keeps the all-ones code
    typedef enum logic [`STATE_WIDTH-1:0] {
        Fetch       = 4'h0,
        Decode      = 4'h1,
        AddrCompute = 4'h2,
        MemRead     = 4'h3,
        WriteBack   = 4'h4,
        MemWrite    = 4'h5,
        Execute     = 4'h6,
        RTypeDone   = 4'h7,
        BeqDone     = 4'h8,
        JumpDone    = 4'h9,
        BneDone     = 4'hA,
        Reset       = 4'hF
    } ControlState;

    typedef struct packed {
        // 00 none, 01 beq, 10 bne
        logic [1:0] pcWriteCond;
        logic       pcWrite;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       irWrite;
        logic [1:0] pcSource;
        logic [1:0] aluOp;
        logic [1:0] aluSrcB;
        logic       aluSrcA;
        logic       regWrite;
        logic       regDst;
    } ControlWord;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] writeData;
        logic                   read;
        logic                   write;
    } MemRequest;

endpackage

//--- source/Alu.sv
`timescale 1ns/1ns
`include "CpuMacros_macros.svh"

module Alu (
    input  logic [1:0]             aluOp,
    input  CpuPkg::Funct           funct,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);

    typedef enum logic [2:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpSlt
    } AluCtl;

    AluCtl aluCtl;

    // aluOp 00 add, 01 sub, 10 from funct
    always_comb begin
        aluCtl = OpAdd;
        case (aluOp)
            2'b01: aluCtl = OpSub;
            2'b10: begin
                case (funct)
                    CpuPkg::Sub: aluCtl = OpSub;
                    CpuPkg::And: aluCtl = OpAnd;
                    CpuPkg::Or:  aluCtl = OpOr;
                    CpuPkg::Slt: aluCtl = OpSlt;
                    default:     aluCtl = OpAdd;
                endcase
            end
            default: aluCtl = OpAdd;
        endcase
    end

    always_comb begin
        case (aluCtl)
            OpSub:   result = a - b;
            OpAnd:   result = a & b;
            OpOr:    result = a | b;
            // signed compare
            OpSlt:   result = {{(`DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- source/RegisterFile.sv
`timescale 1ns/1ns
`include "CpuMacros_macros.svh"

module RegisterFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic                       writeEnable,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            // $zero stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

//--- source/MultiCycleControl.sv
`timescale 1ns/1ns

module MultiCycleControl (
    input  logic               clk,
    input  logic               rst,
    input  CpuPkg::Opcode      opcode,
    output CpuPkg::ControlWord control
);

    CpuPkg::ControlState state;
    CpuPkg::ControlState nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CpuPkg::Reset;
        end else begin
            state <= nextState;
        end
    end

    // next state
    always_comb begin
        nextState = CpuPkg::Reset;
        case (state)
            CpuPkg::Reset: begin
                nextState = CpuPkg::Fetch;
            end
            CpuPkg::Fetch: begin
                nextState = CpuPkg::Decode;
            end
            CpuPkg::Decode: begin
                case (opcode)
                    CpuPkg::Lw, CpuPkg::Sw: nextState = CpuPkg::AddrCompute;
                    CpuPkg::RType:          nextState = CpuPkg::Execute;
                    CpuPkg::Beq:            nextState = CpuPkg::BeqDone;
                    CpuPkg::Bne:            nextState = CpuPkg::BneDone;
                    CpuPkg::J:              nextState = CpuPkg::JumpDone;
                    // unknown opcode is skipped
                    default:                nextState = CpuPkg::Reset;
                endcase
            end
            CpuPkg::AddrCompute: begin
                if (opcode == CpuPkg::Lw) begin
                    nextState = CpuPkg::MemRead;
                end else if (opcode == CpuPkg::Sw) begin
                    nextState = CpuPkg::MemWrite;
                end
            end
            CpuPkg::MemRead: begin
                nextState = CpuPkg::WriteBack;
            end
            CpuPkg::Execute: begin
                nextState = CpuPkg::RTypeDone;
            end
            CpuPkg::WriteBack, CpuPkg::MemWrite, CpuPkg::RTypeDone,
            CpuPkg::BeqDone, CpuPkg::BneDone, CpuPkg::JumpDone: begin
                nextState = CpuPkg::Fetch;
            end
            default: begin
                nextState = CpuPkg::Reset;
            end
        endcase
    end

    // one control word per state with everything low unless raised
    always_comb begin
        control = '0;
        case (state)
            CpuPkg::Fetch: begin
                // IR = mem[PC], PC = PC + 4
                control.memRead = 1'b1;
                control.irWrite = 1'b1;
                control.aluSrcB = 2'b01;
                control.pcWrite = 1'b1;
            end
            CpuPkg::Decode: begin
                // branch target into ALUOut
                control.aluSrcB = 2'b11;
            end
            CpuPkg::AddrCompute: begin
                control.aluSrcA = 1'b1;
                control.aluSrcB = 2'b10;
            end
            CpuPkg::MemRead: begin
                control.memRead = 1'b1;
                control.iorD = 1'b1;
            end
            CpuPkg::WriteBack: begin
                // rt = MDR
                control.regWrite = 1'b1;
                control.memToReg = 1'b1;
            end
            CpuPkg::MemWrite: begin
                control.memWrite = 1'b1;
                control.iorD = 1'b1;
            end
            CpuPkg::Execute: begin
                control.aluSrcA = 1'b1;
                control.aluOp = 2'b10;
            end
            CpuPkg::RTypeDone: begin
                // rd = ALUOut
                control.regDst = 1'b1;
                control.regWrite = 1'b1;
            end
            CpuPkg::BeqDone, CpuPkg::BneDone: begin
                // compare A and B with the target already in ALUOut
                control.aluSrcA = 1'b1;
                control.aluOp = 2'b01;
                control.pcSource = 2'b01;
                control.pcWriteCond = (state == CpuPkg::BeqDone) ? 2'b01 : 2'b10;
            end
            CpuPkg::JumpDone: begin
                control.pcWrite = 1'b1;
                control.pcSource = 2'b10;
            end
            default: begin
                control = '0;
            end
        endcase
    end

endmodule

//--- source/MultiCycleDatapath.sv
`timescale 1ns/1ns
`include "CpuMacros_macros.svh"

module MultiCycleDatapath (
    input  logic                   clk,
    input  logic                   rst,
    input  CpuPkg::ControlWord     control,
    input  logic [`DATA_WIDTH-1:0] memReadData,
    output CpuPkg::Opcode          opcode,
    output CpuPkg::MemRequest      memReq
);

    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] ir;
    logic [`DATA_WIDTH-1:0] mdr;
    logic [`DATA_WIDTH-1:0] regA;
    logic [`DATA_WIDTH-1:0] regB;
    logic [`DATA_WIDTH-1:0] aluOut;

    logic [`DATA_WIDTH-1:0] rfDataA;
    logic [`DATA_WIDTH-1:0] rfDataB;
    logic [`DATA_WIDTH-1:0] signImm;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] pcNext;
    logic [`DATA_WIDTH-1:0] rfWriteData;
    logic [`REG_ADDR_WIDTH-1:0] rfWriteAddr;
    logic                   aluZero;
    logic                   pcEnable;

    // instruction fields
    assign opcode = CpuPkg::Opcode'(ir[31:26]);
    assign signImm = {{(`DATA_WIDTH-`IMM_WIDTH){ir[15]}}, ir[`IMM_WIDTH-1:0]};
    // PC already holds PC+4 here
    assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

    // program counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (pcEnable) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (control.irWrite) begin
            ir <= memReadData;
        end
        mdr <= memReadData;
        regA <= rfDataA;
        regB <= rfDataB;
        aluOut <= aluResult;
    end

    // 01 beq on zero, 10 bne on not zero
    assign pcEnable = control.pcWrite
                    | (control.pcWriteCond == 2'b01 &&  aluZero)
                    | (control.pcWriteCond == 2'b10 && !aluZero);

    always_comb begin
        case (control.pcSource)
            2'b01:   pcNext = aluOut;
            2'b10:   pcNext = jumpTarget;
            default: pcNext = aluResult;
        endcase
    end

    // operand select
    assign srcA = control.aluSrcA ? regA : pc;

    always_comb begin
        case (control.aluSrcB)
            2'b01:   srcB = `DATA_WIDTH'(4);
            2'b10:   srcB = signImm;
            2'b11:   srcB = {signImm[`DATA_WIDTH-3:0], 2'b00};
            default: srcB = regB;
        endcase
    end

    // write-back select of rt for loads and rd for R-type
    assign rfWriteAddr = control.regDst ? ir[15:11] : ir[20:16];
    assign rfWriteData = control.memToReg ? mdr : aluOut;

    RegisterFile regFile (
        .clk         (clk),
        .rst         (rst),
        .readAddrA   (ir[25:21]),
        .readAddrB   (ir[20:16]),
        .writeAddr   (rfWriteAddr),
        .writeEnable (control.regWrite),
        .writeData   (rfWriteData),
        .readDataA   (rfDataA),
        .readDataB   (rfDataB)
    );

    Alu alu (
        .aluOp  (control.aluOp),
        .funct  (CpuPkg::Funct'(ir[5:0])),
        .a      (srcA),
        .b      (srcB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // instruction fetch uses PC, loads and stores use ALUOut
    assign memReq.addr = control.iorD ? aluOut : pc;
    assign memReq.writeData = regB;
    assign memReq.read = control.memRead;
    assign memReq.write = control.memWrite;

endmodule

//--- source/MultiCycleCpu.sv
`timescale 1ns/1ns
`include "CpuMacros_macros.svh"

module MultiCycleCpu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] memReadData,
    output CpuPkg::MemRequest      memReq
);

    CpuPkg::ControlWord control;
    CpuPkg::Opcode      opcode;

    // sequencing FSM
    MultiCycleControl controlUnit (
        .clk     (clk),
        .rst     (rst),
        .opcode  (opcode),
        .control (control)
    );

    // registers, ALU and memory port
    MultiCycleDatapath datapath (
        .clk         (clk),
        .rst         (rst),
        .control     (control),
        .memReadData (memReadData),
        .opcode      (opcode),
        .memReq      (memReq)
    );

endmodule

//--- tests/MultiCycleCpuTb.sv
`timescale 1ns/1ns
`include "CpuMacros_macros.svh"

module MultiCycleCpuTb;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } StoreRecord;

    localparam int MemWords = 256;
    localparam logic [`DATA_WIDTH-1:0] DataBase = 32'h0000_0100;

    logic                   clk;
    logic                   rst;
    logic [`DATA_WIDTH-1:0] memReadData;
    CpuPkg::MemRequest      memReq;

    logic [`DATA_WIDTH-1:0] mem [MemWords];
    logic [`DATA_WIDTH-1:0] refMem [MemWords];
    logic [`DATA_WIDTH-1:0] expFetch [$];
    logic [`DATA_WIDTH-1:0] skippedAddrs [$];
    int                     expCycles [$];
    StoreRecord             expStores [$];
    int cycleCount = 0;
    int cycleLimit = 0;
    int nextFetchCycle = 2;
    int fetchIndex = 0;
    int storeIndex = 0;

    MultiCycleCpu UUT (.clk(clk), .rst(rst), .memReadData(memReadData), .memReq(memReq));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // shared instruction and data memory
    assign memReadData = mem[memReq.addr[9:2]];

    always @(posedge clk) begin
        if (memReq.write) begin
            mem[memReq.addr[9:2]] <= memReq.writeData;
        end
    end

    function automatic logic [31:0] encodeImm(CpuPkg::Opcode op, logic [4:0] rs, logic [4:0] rt,
                                              logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeReg(CpuPkg::Funct fn, logic [4:0] rd, logic [4:0] rs,
                                              logic [4:0] rt);
        return {CpuPkg::RType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeJump(logic [25:0] wordIndex);
        return {CpuPkg::J, wordIndex};
    endfunction

    task automatic reportError(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic loadProgram();
        // base register $8 comes from the data area
        mem[0]  = encodeImm(CpuPkg::Lw, 0, 8, 16'h0108);
        mem[1]  = encodeImm(CpuPkg::Lw, 8, 1, 16'h0000);
        mem[2]  = encodeImm(CpuPkg::Lw, 8, 2, 16'h0004);
        mem[3]  = encodeReg(CpuPkg::Add, 3, 1, 2);
        mem[4]  = encodeImm(CpuPkg::Sw, 8, 3, 16'h0010);
        mem[5]  = encodeReg(CpuPkg::Sub, 4, 1, 2);
        mem[6]  = encodeImm(CpuPkg::Sw, 8, 4, 16'h0014);
        mem[7]  = encodeReg(CpuPkg::And, 5, 1, 2);
        mem[8]  = encodeImm(CpuPkg::Sw, 8, 5, 16'h0018);
        mem[9]  = encodeReg(CpuPkg::Or, 6, 1, 2);
        mem[10] = encodeImm(CpuPkg::Sw, 8, 6, 16'h001C);
        mem[11] = encodeReg(CpuPkg::Slt, 7, 1, 2);
        mem[12] = encodeImm(CpuPkg::Sw, 8, 7, 16'h0020);
        // taken beq over a poison store
        mem[13] = encodeImm(CpuPkg::Beq, 1, 1, 16'h0001);
        mem[14] = encodeImm(CpuPkg::Sw, 8, 8, 16'h0040);
        // not-taken beq lets the marker store run
        mem[15] = encodeImm(CpuPkg::Beq, 8, 0, 16'h0001);
        mem[16] = encodeImm(CpuPkg::Sw, 8, 8, 16'h0044);
        // taken bne over a poison store
        mem[17] = encodeImm(CpuPkg::Bne, 8, 0, 16'h0001);
        mem[18] = encodeImm(CpuPkg::Sw, 8, 8, 16'h0048);
        // not-taken bne falls through to a store of the second loaded operand
        mem[19] = encodeImm(CpuPkg::Bne, 8, 8, 16'h0001);
        mem[20] = encodeImm(CpuPkg::Sw, 8, 2, 16'h004C);
        // jump over a poison store into the final loop
        mem[21] = encodeJump(23);
        mem[22] = encodeImm(CpuPkg::Sw, 8, 8, 16'h0050);
        mem[23] = encodeJump(23);
        mem[64] = $urandom();
        mem[65] = $urandom();
        mem[66] = DataBase;
        skippedAddrs.push_back(DataBase + 32'h40);
        skippedAddrs.push_back(DataBase + 32'h48);
        skippedAddrs.push_back(DataBase + 32'h50);
    endtask

    // ISA-level walk of the program path until it jumps to itself
    task automatic buildExpected();
        logic [`DATA_WIDTH-1:0] regs [32];
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] pcPlus4;
        logic [`DATA_WIDTH-1:0] nextPc;
        logic [`DATA_WIDTH-1:0] instr;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`DATA_WIDTH-1:0] rsVal;
        logic [`DATA_WIDTH-1:0] rtVal;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] result;
        int cycles;
        int total;
        total = 0;
        pc = `RESET_PC;
        foreach (regs[i]) regs[i] = '0;
        for (int step = 0; step < 100; step++) begin
            instr = refMem[pc[9:2]];
            imm = {{16{instr[15]}}, instr[15:0]};
            rsVal = regs[instr[25:21]];
            rtVal = regs[instr[20:16]];
            addr = rsVal + imm;
            pcPlus4 = pc + 4;
            nextPc = pcPlus4;
            cycles = 3;
            case (CpuPkg::Opcode'(instr[31:26]))
                CpuPkg::Lw: begin
                    regs[instr[20:16]] = refMem[addr[9:2]];
                    cycles = 5;
                end
                CpuPkg::Sw: begin
                    refMem[addr[9:2]] = rtVal;
                    expStores.push_back('{addr, rtVal});
                    cycles = 4;
                end
                CpuPkg::RType: begin
                    case (CpuPkg::Funct'(instr[5:0]))
                        CpuPkg::Sub: result = rsVal - rtVal;
                        CpuPkg::And: result = rsVal & rtVal;
                        CpuPkg::Or:  result = rsVal | rtVal;
                        CpuPkg::Slt: result = ($signed(rsVal) < $signed(rtVal)) ? 1 : 0;
                        default:     result = rsVal + rtVal;
                    endcase
                    regs[instr[15:11]] = result;
                    cycles = 4;
                end
                CpuPkg::Beq: if (rsVal == rtVal) nextPc = pcPlus4 + (imm << 2);
                CpuPkg::Bne: if (rsVal != rtVal) nextPc = pcPlus4 + (imm << 2);
                CpuPkg::J:   nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
                default:     nextPc = pcPlus4;
            endcase
            regs[0] = '0;
            expFetch.push_back(pc);
            expCycles.push_back(cycles);
            total += cycles;
            if (nextPc == pc) break;
            pc = nextPc;
        end
        cycleLimit = 2 * total + 100;
    endtask

    task automatic checkStore();
        StoreRecord expected;
        foreach (skippedAddrs[i]) begin
            assert (memReq.addr != skippedAddrs[i])
                else reportError($sformatf("skipped store reached 0x%08h", memReq.addr));
        end
        assert (storeIndex < expStores.size())
            else reportError($sformatf("unexpected store to 0x%08h", memReq.addr));
        expected = expStores[storeIndex];
        assert (memReq.addr == expected.addr && memReq.writeData == expected.data)
            else reportError($sformatf("store %0d expected 0x%08h at 0x%08h, saw 0x%08h at 0x%08h",
                storeIndex, expected.data, expected.addr, memReq.writeData, memReq.addr));
        storeIndex++;
    endtask

    task automatic checkFetch();
        assert (memReq.read && memReq.addr == expFetch[fetchIndex])
            else reportError($sformatf("fetch %0d expected at 0x%08h, saw read %b at 0x%08h",
                fetchIndex, expFetch[fetchIndex], memReq.read, memReq.addr));
        nextFetchCycle += expCycles[fetchIndex];
        fetchIndex++;
        if (fetchIndex == expFetch.size()) begin
            assert (storeIndex == expStores.size()) begin
                $display("TESTS PASSED");
                $finish;
            end else begin
                reportError($sformatf("%0d of %0d stores seen", storeIndex, expStores.size()));
            end
        end
    endtask

    // strobes low in reset, in the cycle after it, then fetch at the reset PC
    assert property (@(posedge clk) rst |-> !memReq.read && !memReq.write)
        else reportError("memory strobe high during reset");
    assert property (@(posedge clk) $fell(rst) |-> !memReq.read && !memReq.write)
        else reportError("memory strobe high in the first cycle after reset");
    assert property (@(posedge clk) $fell(rst) |=> memReq.read && memReq.addr == `RESET_PC)
        else reportError("first fetch is not at the reset PC");
    assert property (@(posedge clk) disable iff (rst) !(memReq.read && memReq.write))
        else reportError("read and write strobes high together");

    initial begin
        rst = 1'b1;
        void'($urandom(16280));
        // fill word holds its own byte address
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = 32'hBAD0_0000 | (i << 2);
        end
        loadProgram();
        refMem = mem;
        buildExpected();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

    // mid-cycle sampling of the memory port
    always @(negedge clk) begin
        if (!rst) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("Timeout after %0d cycles, program never reached its final loop",
                         cycleCount);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end else begin
                if (memReq.write) checkStore();
                if (cycleCount == nextFetchCycle) checkFetch();
            end
        end
    end

endmodule

//--- MultiCycleCpu.f
+incdir+source
source/CpuPkg.sv
source/Alu.sv
source/RegisterFile.sv
source/MultiCycleControl.sv
source/MultiCycleDatapath.sv
source/MultiCycleCpu.sv
tests/MultiCycleCpuTb.sv

//--- Bender.yml
package:
  name: multi_cycle_cpu

sources:
  - include_dirs:
      - source
    files:
      - source/CpuPkg.sv
      - source/Alu.sv
      - source/RegisterFile.sv
      - source/MultiCycleControl.sv
      - source/MultiCycleDatapath.sv
      - source/MultiCycleCpu.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/MultiCycleCpuTb.sv
